// File: list.f
axil_iob_pkg.sv
axil2iob.sv
iob_slot_decoder.sv
iob_reg_bank.sv
iob_rsp_mux.sv
axil_iob_subsys.sv
tb_clk_gen.sv
tb_checker.sv
tb_axil_iob.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_axil_iob -f list.f -o sim_axil_iob

result=$(./obj_dir/sim_axil_iob)
echo "$result"
echo "$result" | grep -qx "Everything OK"

// File: tb_axil_iob.sv
`timescale 1ns/1ps

module tb_axil_iob
   import axil_iob_pkg::*;
();

   localparam int ADDR_W        = 16;
   localparam int DATA_W        = 32;
   localparam int N_SLOTS       = 4;
   localparam int REGS_PER_SLOT = 4;
   localparam int STRB_W        = DATA_W / BYTE_W;
   localparam int N_WORDS       = N_SLOTS * REGS_PER_SLOT;
   localparam int N_RAND        = 120;
   localparam int RST_CYCLES    = 2;
   // a random step may be a write followed by a read
   localparam int N_OPS         = 3 * N_WORDS + 16 + 8 + N_WORDS + 2 * N_RAND;

   logic              clk;
   logic              rst;
   logic [ADDR_W-1:0] axil_awaddr;
   logic              axil_awvalid;
   logic              axil_awready;
   logic [DATA_W-1:0] axil_wdata;
   logic [STRB_W-1:0] axil_wstrb;
   logic              axil_wvalid;
   logic              axil_wready;
   axil_resp_t        axil_bresp;
   logic              axil_bvalid;
   logic              axil_bready;
   logic [ADDR_W-1:0] axil_araddr;
   logic              axil_arvalid;
   logic              axil_arready;
   logic [DATA_W-1:0] axil_rdata;
   axil_resp_t        axil_rresp;
   logic              axil_rvalid;
   logic              axil_rready;
   int                error_count;
   int                check_count;
   int                tests_run = 0;
   int                errors_before = 0;
   bit                bp_on = 1'b0;

   tb_clk_gen #(.PERIOD(100), .RST_CYCLES(RST_CYCLES)) u_clk_gen (.*);

   axil_iob_subsys #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .N_SLOTS(N_SLOTS), .REGS_PER_SLOT(REGS_PER_SLOT)
   ) u_axil_iob_subsys (.*);

   tb_checker #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .N_SLOTS(N_SLOTS), .REGS_PER_SLOT(REGS_PER_SLOT)
   ) u_checker (.*);

   function automatic logic [ADDR_W-1:0] word_addr(input int word);
      return ADDR_W'(word * STRB_W);
   endfunction

   // ready low on about a third of the cycles under back-pressure
   function automatic logic draw_ready();
      return !bp_on || (($urandom % 3) != 0);
   endfunction

   task automatic take_response(input bit is_write);
      bit done;
      done = 1'b0;
      while (!done) begin
         if (is_write) begin
            axil_bready <= draw_ready();
         end else begin
            axil_rready <= draw_ready();
         end
         @(posedge clk);
         done = is_write ? (axil_bvalid && axil_bready) : (axil_rvalid && axil_rready);
      end
      axil_bready <= 1'b0;
      axil_rready <= 1'b0;
   endtask

   // with both kinds offered the write must be taken first
   task automatic transfer(input bit wr, input bit rd, input logic [ADDR_W-1:0] waddr,
                           input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb,
                           input logic [ADDR_W-1:0] raddr);
      if (wr) begin
         axil_awaddr  <= waddr;
         axil_awvalid <= 1'b1;
         axil_wdata   <= wdata;
         axil_wstrb   <= wstrb;
         axil_wvalid  <= 1'b1;
      end
      if (rd) begin
         axil_araddr  <= raddr;
         axil_arvalid <= 1'b1;
      end
      if (wr) begin
         do begin
            @(posedge clk);
         end while (!(axil_awready && axil_wready));
         axil_awvalid <= 1'b0;
         axil_wvalid  <= 1'b0;
         take_response(1'b1);
      end
      if (rd) begin
         do begin
            @(posedge clk);
         end while (!axil_arready);
         axil_arvalid <= 1'b0;
         take_response(1'b0);
      end
   endtask

   task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
      transfer(1'b1, 1'b0, addr, data, strb, '0);
   endtask

   task automatic read_word(input logic [ADDR_W-1:0] addr);
      transfer(1'b0, 1'b1, '0, '0, '0, addr);
   endtask

   // one extra edge lets the checker finish the last response
   task automatic finish_test(input string name);
      int n;
      @(posedge clk);
      n = error_count - errors_before;
      tests_run++;
      if (n == 0) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         $display("test %0d %s: %0d errors", tests_run, name, n);
      end
      errors_before = error_count;
   endtask

   initial begin
      int                kind;
      int                word;
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      void'($urandom(32'h58d9));
      axil_awaddr  <= '0;
      axil_awvalid <= 1'b0;
      axil_wdata   <= '0;
      axil_wstrb   <= '0;
      axil_wvalid  <= 1'b0;
      axil_bready  <= 1'b0;
      axil_araddr  <= '0;
      axil_arvalid <= 1'b0;
      axil_rready  <= 1'b0;
      @(negedge rst);
      @(posedge clk);

      for (int w = 0; w < N_WORDS; w++) begin
         read_word(word_addr(w));
      end
      finish_test("reset values");

      for (int w = 0; w < N_WORDS; w++) begin
         write_word(word_addr(w), DATA_W'($urandom()), '1);
      end
      for (int w = 0; w < N_WORDS; w++) begin
         read_word(word_addr(w));
      end
      finish_test("full-word write and read back");

      // strobe patterns 1 to 8, each followed by a read of that word
      for (int w = 0; w < 8; w++) begin
         write_word(word_addr(2 * w), DATA_W'($urandom()), STRB_W'(w + 1));
         read_word(word_addr(2 * w));
      end
      finish_test("partial strobes");

      for (int k = 0; k < 4; k++) begin
         write_word(word_addr(N_WORDS + 3 * k), DATA_W'($urandom()), '1);
         read_word(word_addr(N_WORDS + 5 * k));
      end
      for (int w = 0; w < N_WORDS; w++) begin
         read_word(word_addr(w));
      end
      finish_test("out-of-range slots");

      bp_on = 1'b1;
      for (int i = 0; i < N_RAND; i++) begin
         kind = $urandom % 4;
         word = $urandom % (N_WORDS + REGS_PER_SLOT);
         data = DATA_W'($urandom());
         strb = STRB_W'($urandom());
         if (strb == '0) begin
            strb = '1;
         end
         case (kind)
            0: write_word(word_addr(word), data, strb);
            1: transfer(1'b1, 1'b1, word_addr(word), data, strb, word_addr(word));
            default: read_word(word_addr(word));
         endcase
      end
      bp_on = 1'b0;
      finish_test("random mix with back-pressure");

      $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, check_count, error_count);
      if (error_count == 0 && check_count > 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // a transaction takes far fewer than 40 cycles even under back-pressure
   initial begin
      repeat (N_OPS * 40 + RST_CYCLES) @(posedge clk);
      $display("timeout: the tests did not finish within %0d clock cycles",
               N_OPS * 40 + RST_CYCLES);
      $display("Something failed");
      $finish;
   end

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker
   import axil_iob_pkg::*;
#(
   parameter int ADDR_W        = 16,
   parameter int DATA_W        = 32,
   parameter int N_SLOTS       = 4,
   parameter int REGS_PER_SLOT = 4,
   localparam int STRB_W       = DATA_W / BYTE_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic [ADDR_W-1:0] axil_awaddr,
   input  logic              axil_awvalid,
   input  logic              axil_awready,
   input  logic [DATA_W-1:0] axil_wdata,
   input  logic [STRB_W-1:0] axil_wstrb,
   input  logic              axil_wvalid,
   input  logic              axil_wready,
   input  axil_resp_t        axil_bresp,
   input  logic              axil_bvalid,
   input  logic              axil_bready,
   input  logic [ADDR_W-1:0] axil_araddr,
   input  logic              axil_arvalid,
   input  logic              axil_arready,
   input  logic [DATA_W-1:0] axil_rdata,
   input  axil_resp_t        axil_rresp,
   input  logic              axil_rvalid,
   input  logic              axil_rready,
   output int                error_count,
   output int                check_count
);

   // edges from acceptance to the first edge that sees the response valid
   localparam int RSP_LAT = 3;

   logic [DATA_W-1:0] shadow [N_SLOTS*REGS_PER_SLOT];
   logic [ADDR_W-1:0] rd_addr;
   axil_resp_t        exp_bresp;
   int                since_accept = 0;
   logic              rsp_seen = 1'b1;
   int                errors = 0;
   int                checks = 0;

   assign error_count = errors;
   assign check_count = checks;

   // shadow word and OKAY in range, zero and SLVERR past the last slot
   function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr,
                                                       output axil_resp_t resp);
      int word;
      word = int'(addr) / STRB_W;
      if (word / REGS_PER_SLOT < N_SLOTS) begin
         resp = RESP_OKAY;
         return shadow[word];
      end
      resp = RESP_SLVERR;
      return '0;
   endfunction

   always @(posedge clk) begin
      axil_resp_t        exp_resp;
      logic [DATA_W-1:0] exp_data;
      int                word;
      if (rst) begin
         foreach (shadow[i]) begin
            shadow[i] = '0;
         end
         since_accept = 0;
         rsp_seen     = 1'b1;
      end else begin
         since_accept++;
         if (axil_arready && axil_awvalid && axil_wvalid) begin
            $display("t=%0t a read address was accepted while a write was offered", $time);
            errors++;
         end
         if (axil_awready !== axil_wready) begin
            $display("t=%0t write address and write data were not accepted together", $time);
            errors++;
         end
         // first edge of a response valid
         if ((axil_bvalid || axil_rvalid) && !rsp_seen) begin
            rsp_seen = 1'b1;
            checks++;
            if (since_accept != RSP_LAT) begin
               $display("FAIL t=%0t %s latency expected %0d got %0d", $time,
                        axil_bvalid ? "axil_bvalid" : "axil_rvalid", RSP_LAT, since_accept);
               errors++;
            end
         end
         // write handshake, update the shadow before any later read
         if (axil_awvalid && axil_awready) begin
            void'(expected_read(axil_awaddr, exp_bresp));
            word = int'(axil_awaddr) / STRB_W;
            if (exp_bresp == RESP_OKAY) begin
               for (int b = 0; b < STRB_W; b++) begin
                  if (axil_wstrb[b]) begin
                     shadow[word][b*BYTE_W +: BYTE_W] = axil_wdata[b*BYTE_W +: BYTE_W];
                  end
               end
            end
            since_accept = 0;
            rsp_seen     = 1'b0;
         end
         if (axil_arvalid && axil_arready) begin
            rd_addr      = axil_araddr;
            since_accept = 0;
            rsp_seen     = 1'b0;
         end
         if (axil_bvalid && axil_bready) begin
            checks++;
            if (axil_bresp !== exp_bresp) begin
               $display("FAIL t=%0t axil_bresp expected %0d got %0d",
                        $time, exp_bresp, axil_bresp);
               errors++;
            end
         end
         if (axil_rvalid && axil_rready) begin
            exp_data = expected_read(rd_addr, exp_resp);
            checks++;
            if (axil_rresp !== exp_resp) begin
               $display("FAIL t=%0t axil_rresp expected %0d got %0d",
                        $time, exp_resp, axil_rresp);
               errors++;
            end
            if (axil_rdata !== exp_data) begin
               $display("FAIL t=%0t axil_rdata expected %h got %h",
                        $time, exp_data, axil_rdata);
               errors++;
            end
         end
      end
   end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD     = 100,
   parameter int RST_CYCLES = 2
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

   // reset released on a rising edge
   initial begin
      rst <= 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

// File: axil_iob_subsys.sv
`timescale 1ns/1ps

module axil_iob_subsys
   import axil_iob_pkg::*;
#(
   parameter int ADDR_W        = 16,
   parameter int DATA_W        = 32,
   parameter int N_SLOTS       = 4,
   parameter int REGS_PER_SLOT = 4,
   localparam int STRB_W       = DATA_W / BYTE_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic [ADDR_W-1:0] axil_awaddr,
   input  logic              axil_awvalid,
   output logic              axil_awready,
   input  logic [DATA_W-1:0] axil_wdata,
   input  logic [STRB_W-1:0] axil_wstrb,
   input  logic              axil_wvalid,
   output logic              axil_wready,
   output axil_resp_t        axil_bresp,
   output logic              axil_bvalid,
   input  logic              axil_bready,
   input  logic [ADDR_W-1:0] axil_araddr,
   input  logic              axil_arvalid,
   output logic              axil_arready,
   output logic [DATA_W-1:0] axil_rdata,
   output axil_resp_t        axil_rresp,
   output logic              axil_rvalid,
   input  logic              axil_rready
);

   localparam int OFF_W = $clog2(REGS_PER_SLOT);
   localparam int IDX_W = idx_w(N_SLOTS);

   logic                           iob_valid;
   logic [ADDR_W-1:0]              iob_addr;
   logic [DATA_W-1:0]              iob_wdata;
   logic [STRB_W-1:0]              iob_wstrb;
   logic                           iob_ready;
   logic [DATA_W-1:0]              iob_rdata;
   logic                           iob_err;
   logic [N_SLOTS-1:0]             slot_valid;
   logic [OFF_W-1:0]               offset;
   logic [IDX_W-1:0]               sel_idx;
   logic                           sel_miss;
   logic                           miss_valid;
   logic [N_SLOTS-1:0]             slot_ready;
   logic [N_SLOTS-1:0][DATA_W-1:0] slot_rdata;

   axil2iob #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_axil2iob (
      .clk, .rst,
      .axil_awaddr, .axil_awvalid, .axil_awready,
      .axil_wdata, .axil_wstrb, .axil_wvalid, .axil_wready,
      .axil_bresp, .axil_bvalid, .axil_bready,
      .axil_araddr, .axil_arvalid, .axil_arready,
      .axil_rdata, .axil_rresp, .axil_rvalid, .axil_rready,
      .iob_valid, .iob_addr, .iob_wdata, .iob_wstrb,
      .iob_ready, .iob_rdata, .iob_err
   );

   iob_slot_decoder #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .N_SLOTS(N_SLOTS), .REGS_PER_SLOT(REGS_PER_SLOT)
   ) u_decoder (
      .clk, .rst, .iob_valid, .iob_addr,
      .slot_valid, .offset, .sel_idx, .sel_miss, .miss_valid
   );

   // one bank per slot, request fields shared
   for (genvar i = 0; i < N_SLOTS; i++) begin : g_bank
      iob_reg_bank #(.DATA_W(DATA_W), .REGS_PER_SLOT(REGS_PER_SLOT)) u_bank (
         .clk, .rst,
         .valid (slot_valid[i]),
         .offset(offset),
         .wdata (iob_wdata),
         .wstrb (iob_wstrb),
         .ready (slot_ready[i]),
         .rdata (slot_rdata[i])
      );
   end

   iob_rsp_mux #(.N_SLOTS(N_SLOTS), .DATA_W(DATA_W)) u_rsp_mux (
      .sel_idx, .sel_miss, .miss_valid, .slot_ready, .slot_rdata,
      .iob_ready, .iob_rdata, .iob_err
   );

endmodule

// File: iob_rsp_mux.sv
`timescale 1ns/1ps

module iob_rsp_mux
   import axil_iob_pkg::*;
#(
   parameter int N_SLOTS = 4,
   parameter int DATA_W  = 32,
   localparam int IDX_W  = idx_w(N_SLOTS)
) (
   input  logic [IDX_W-1:0]                sel_idx,
   input  logic                            sel_miss,
   input  logic                            miss_valid,
   input  logic [N_SLOTS-1:0]              slot_ready,
   input  logic [N_SLOTS-1:0][DATA_W-1:0]  slot_rdata,
   output logic                            iob_ready,
   output logic [DATA_W-1:0]               iob_rdata,
   output logic                            iob_err
);

   // a miss never indexes the banks
   always_comb begin
      if (sel_miss) begin
         iob_ready = miss_valid;
         iob_rdata = '0;
      end else begin
         iob_ready = slot_ready[sel_idx];
         iob_rdata = slot_rdata[sel_idx];
      end
   end

   assign iob_err = sel_miss;

endmodule

// File: iob_reg_bank.sv
`timescale 1ns/1ps

module iob_reg_bank
   import axil_iob_pkg::*;
#(
   parameter int DATA_W        = 32,
   parameter int REGS_PER_SLOT = 4,
   localparam int OFF_W        = $clog2(REGS_PER_SLOT),
   localparam int STRB_W       = DATA_W / BYTE_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              valid,
   input  logic [OFF_W-1:0]  offset,
   input  logic [DATA_W-1:0] wdata,
   input  logic [STRB_W-1:0] wstrb,
   output logic              ready,
   output logic [DATA_W-1:0] rdata
);

   logic [DATA_W-1:0] regs [REGS_PER_SLOT];

   // byte-lane writes, a zero strobe writes nothing
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < REGS_PER_SLOT; i++) begin
            regs[i] <= '0;
         end
      end else if (valid) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wstrb[b]) begin
               regs[offset][b*BYTE_W +: BYTE_W] <= wdata[b*BYTE_W +: BYTE_W];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (valid && (wstrb == '0)) begin
         rdata <= regs[offset];
      end
   end

   // answer one cycle after the request
   always_ff @(posedge clk) begin
      if (rst) begin
         ready <= 1'b0;
      end else begin
         ready <= valid;
      end
   end

endmodule

// File: iob_slot_decoder.sv
`timescale 1ns/1ps

module iob_slot_decoder
   import axil_iob_pkg::*;
#(
   parameter int ADDR_W        = 16,
   parameter int DATA_W        = 32,
   parameter int N_SLOTS       = 4,
   parameter int REGS_PER_SLOT = 4,
   localparam int BYTE_SHIFT   = $clog2(DATA_W / BYTE_W),
   localparam int OFF_W        = $clog2(REGS_PER_SLOT),
   localparam int SLOT_W       = ADDR_W - BYTE_SHIFT - OFF_W,
   localparam int IDX_W        = idx_w(N_SLOTS)
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               iob_valid,
   input  logic [ADDR_W-1:0]  iob_addr,
   output logic [N_SLOTS-1:0] slot_valid,
   output logic [OFF_W-1:0]   offset,
   output logic [IDX_W-1:0]   sel_idx,
   output logic               sel_miss,
   output logic               miss_valid
);

   logic [SLOT_W-1:0] slot_num;
   logic              miss;

   // byte address -> word -> slot and offset
   assign offset   = iob_addr[BYTE_SHIFT +: OFF_W];
   assign slot_num = iob_addr[ADDR_W-1 -: SLOT_W];
   assign miss     = (slot_num >= SLOT_W'(N_SLOTS));

   always_comb begin
      for (int i = 0; i < N_SLOTS; i++) begin
         slot_valid[i] = iob_valid && (slot_num == SLOT_W'(i));
      end
   end

   // index only matters when not a miss
   always_ff @(posedge clk) begin
      if (iob_valid) begin
         sel_idx <= slot_num[IDX_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         sel_miss   <= 1'b0;
         miss_valid <= 1'b0;
      end else begin
         if (iob_valid) begin
            sel_miss <= miss;
         end
         miss_valid <= iob_valid && miss;
      end
   end

   // one-cycle request, so the registered selection holds for the answer
   a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
      iob_valid |=> !iob_valid);

endmodule

// File: axil2iob.sv
`timescale 1ns/1ps

module axil2iob
   import axil_iob_pkg::*;
#(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32,
   localparam int STRB_W = DATA_W / BYTE_W
) (
   input  logic              clk,
   input  logic              rst,

   // AXI-Lite slave
   input  logic [ADDR_W-1:0] axil_awaddr,
   input  logic              axil_awvalid,
   output logic              axil_awready,
   input  logic [DATA_W-1:0] axil_wdata,
   input  logic [STRB_W-1:0] axil_wstrb,
   input  logic              axil_wvalid,
   output logic              axil_wready,
   output axil_resp_t        axil_bresp,
   output logic              axil_bvalid,
   input  logic              axil_bready,
   input  logic [ADDR_W-1:0] axil_araddr,
   input  logic              axil_arvalid,
   output logic              axil_arready,
   output logic [DATA_W-1:0] axil_rdata,
   output axil_resp_t        axil_rresp,
   output logic              axil_rvalid,
   input  logic              axil_rready,

   // IOb master
   output logic              iob_valid,
   output logic [ADDR_W-1:0] iob_addr,
   output logic [DATA_W-1:0] iob_wdata,
   output logic [STRB_W-1:0] iob_wstrb,
   input  logic              iob_ready,
   input  logic [DATA_W-1:0] iob_rdata,
   input  logic              iob_err
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_WAIT,
      ST_RESP
   } state_t;

   state_t            state;
   logic              is_write;
   logic              wr_accept;
   logic              rd_accept;
   logic              rsp_done;
   logic [DATA_W-1:0] rdata_q;
   axil_resp_t        resp_q;

   // write needs address and data together and wins over a read
   assign wr_accept = (state == ST_IDLE) && axil_awvalid && axil_wvalid;
   assign rd_accept = (state == ST_IDLE) && axil_arvalid && !(axil_awvalid && axil_wvalid);

   assign axil_awready = wr_accept;
   assign axil_wready  = wr_accept;
   assign axil_arready = rd_accept;

   assign rsp_done = is_write ? axil_bready : axil_rready;

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= ST_IDLE;
         is_write <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (wr_accept || rd_accept) begin
                  state    <= ST_REQ;
                  is_write <= wr_accept;
               end
            end
            ST_REQ: begin
               state <= ST_WAIT;
            end
            ST_WAIT: begin
               if (iob_ready) begin
                  state <= ST_RESP;
               end
            end
            ST_RESP: begin
               if (rsp_done) begin
                  state <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // request capture, strobe zeroed so the IOb side sees a read
   always_ff @(posedge clk) begin
      if (wr_accept) begin
         iob_addr  <= axil_awaddr;
         iob_wdata <= axil_wdata;
         iob_wstrb <= axil_wstrb;
      end else if (rd_accept) begin
         iob_addr  <= axil_araddr;
         iob_wstrb <= '0;
      end
   end

   // response capture
   always_ff @(posedge clk) begin
      if ((state == ST_WAIT) && iob_ready) begin
         rdata_q <= iob_rdata;
         resp_q  <= err_to_resp(iob_err);
      end
   end

   assign iob_valid = (state == ST_REQ);

   assign axil_bvalid = (state == ST_RESP) && is_write;
   assign axil_bresp  = resp_q;
   assign axil_rvalid = (state == ST_RESP) && !is_write;
   assign axil_rdata  = rdata_q;
   assign axil_rresp  = resp_q;

   // the IOb side answers each request exactly one cycle later
   a_ready_after_valid: assert property (@(posedge clk) disable iff (rst)
      iob_valid |=> iob_ready);

   // no answer without a request in flight
   a_ready_in_wait: assert property (@(posedge clk) disable iff (rst)
      iob_ready |-> (state == ST_WAIT));

endmodule

// File: axil_iob_pkg.sv
package axil_iob_pkg;

   // bits per write strobe lane
   localparam int BYTE_W = 8;

   // AXI response code
   typedef logic [1:0] axil_resp_t;

   localparam axil_resp_t RESP_OKAY   = 2'b00;
   localparam axil_resp_t RESP_SLVERR = 2'b10;

   // IOb error flag to AXI response code
   function automatic axil_resp_t err_to_resp(input logic err);
      axil_resp_t resp;
      if (err) begin
         resp = RESP_SLVERR;
      end else begin
         resp = RESP_OKAY;
      end
      return resp;
   endfunction

   // width of a slot index, at least one bit
   function automatic int idx_w(input int n_slots);
      int w;
      if (n_slots > 1) begin
         w = $clog2(n_slots);
      end else begin
         w = 1;
      end
      return w;
   endfunction

endpackage
